// File: common/stack_cpu_pkg.sv
package stack_cpu_pkg;

    // 64 data stack entries
    localparam int data_stack_bits = 6;
    localparam int data_stack_depth = 1 << data_stack_bits;

    // the ALU code used for neg, outside the range of the regular operations
    localparam logic [3:0] alu_neg = 4'd15;

    typedef logic [63:0] word_t;
    typedef logic [31:0] mem_word_t;
    typedef logic [15:0] instr_t;
    typedef logic [31:0] pc_t;
    typedef logic [data_stack_bits-1:0] sp_t;

    // opcode lives in the upper byte of an instruction word
    typedef enum logic [7:0] {
        op_push  = 8'd0,
        op_dup   = 8'd2,
        op_set   = 8'd3,
        op_jmp   = 8'd5,
        op_get   = 8'd6,
        op_hlt   = 8'd12,
        op_neg   = 8'd14,
        op_drop  = 8'd17,
        op_drop2 = 8'd18,
        op_swap  = 8'd19,
        op_over  = 8'd21,
        op_nop   = 8'd25,
        op_ifcmp = 8'd27,
        op_if    = 8'd28,
        op_alu   = 8'd29
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_shl = 4'd5,
        alu_shr = 4'd6,
        alu_sar = 4'd7,
        alu_bit = 4'd8,
        alu_mul = 4'd9,
        alu_cmp = 4'd10
    } alu_op_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_fetch2,
        st_wait_ready,
        st_push_temp
    } cpu_state_t;

    typedef struct packed {
        logic      valid;
        logic      nwr;
        mem_word_t address;
        mem_word_t data;
    } mem_req_t;

    // the stack is written at the pointer after sp_delta has been applied
    typedef struct packed {
        logic              write;
        logic signed [2:0] sp_delta;
        word_t             wr_data;
    } stack_cmd_t;

endpackage

// File: source/data_stack.sv
`timescale 1ns/1ps

module data_stack (
    input  logic                     clk,
    input  logic                     nreset,
    input  stack_cpu_pkg::stack_cmd_t stack_cmd,
    output stack_cpu_pkg::word_t      top,
    output stack_cpu_pkg::word_t      second
);

    // the stack grows towards lower addresses, so the top sits at the pointer
    stack_cpu_pkg::word_t entries [stack_cpu_pkg::data_stack_depth];

    stack_cpu_pkg::sp_t sp;
    stack_cpu_pkg::sp_t sp_next;
    stack_cpu_pkg::sp_t sp_second;
    stack_cpu_pkg::sp_t delta_ext;

    assign delta_ext = {
        {(stack_cpu_pkg::data_stack_bits - 3){stack_cmd.sp_delta[2]}},
        stack_cmd.sp_delta
    };

    // pointer arithmetic wraps around the array without any overflow check
    assign sp_next = sp + delta_ext;
    assign sp_second = sp + 1'b1;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            sp <= '0;
        end else begin
            sp <= sp_next;
        end
    end

    always_ff @(posedge clk) begin
        if (stack_cmd.write) begin
            entries[sp_next] <= stack_cmd.wr_data;
        end
    end

    assign top = entries[sp];
    assign second = entries[sp_second];

endmodule

// File: source/stack_alu.sv
`timescale 1ns/1ps

module stack_alu (
    input  stack_cpu_pkg::word_t top,
    input  stack_cpu_pkg::word_t second,
    input  logic [7:0]           func,
    output stack_cpu_pkg::word_t result,
    output logic                 cond_pass,
    output logic                 cmp_pass
);

    logic       eq;
    logic       gt;
    logic       lt;
    logic       negative;
    logic       zero;
    logic       negate;
    logic [1:0] flag_mask;
    logic [1:0] cond_hits;
    logic [1:0] cmp_hits;

    assign eq = second == top;
    assign gt = $signed(second) > $signed(top);
    assign lt = !eq && !gt;
    assign negative = top[63];
    assign zero = top == '0;

    assign negate = func[2];
    assign flag_mask = func[1:0];

    // if looks at top alone, ifcmp compares second against top
    assign cond_hits = flag_mask & {negative, zero};
    assign cmp_hits = flag_mask & {gt, eq};
    assign cond_pass = (|cond_hits) ^ negate;
    assign cmp_pass = (|cmp_hits) ^ negate;

    always_comb begin
        case (func[3:0])
            stack_cpu_pkg::alu_add: result = second + top;
            stack_cpu_pkg::alu_sub: result = second - top;
            stack_cpu_pkg::alu_and: result = second & top;
            stack_cpu_pkg::alu_or:  result = second | top;
            stack_cpu_pkg::alu_xor: result = second ^ top;
            stack_cpu_pkg::alu_shl: result = second << top;
            stack_cpu_pkg::alu_shr: result = second >> top;
            stack_cpu_pkg::alu_sar: result = $signed(second) >>> top;
            stack_cpu_pkg::alu_bit: result = {63'd0, second[top[5:0]]};
            stack_cpu_pkg::alu_mul: result = $signed(second) * $signed(top);
            // -1, 0 or 1 depending on how second compares to top
            stack_cpu_pkg::alu_cmp: result = {{63{lt}}, !eq};
            stack_cpu_pkg::alu_neg: result = -top;
            default:                result = '0;
        endcase
    end

endmodule

// File: cpu/cpu_control.sv
`timescale 1ns/1ps

module cpu_control (
    input  logic                      clk,
    input  logic                      nreset,
    output stack_cpu_pkg::pc_t        prog_addr,
    input  stack_cpu_pkg::instr_t     prog_data,
    output stack_cpu_pkg::mem_req_t   mem_req,
    input  stack_cpu_pkg::mem_word_t  mem_rdata,
    input  logic                      mem_ready,
    input  stack_cpu_pkg::word_t      top,
    input  stack_cpu_pkg::word_t      second,
    input  stack_cpu_pkg::word_t      alu_result,
    input  logic                      cond_pass,
    input  logic                      cmp_pass,
    output logic [7:0]                alu_func,
    output stack_cpu_pkg::stack_cmd_t stack_cmd,
    output logic                      hlt,
    output logic                      error
);

    stack_cpu_pkg::cpu_state_t state;
    stack_cpu_pkg::pc_t        pc;
    stack_cpu_pkg::instr_t     cur_instr;
    stack_cpu_pkg::instr_t     immediate;
    stack_cpu_pkg::word_t      temp;
    stack_cpu_pkg::opcode_t    opcode;
    stack_cpu_pkg::pc_t        branch_offset;
    stack_cpu_pkg::mem_word_t  push_value;
    stack_cpu_pkg::mem_word_t  mem_address;
    stack_cpu_pkg::mem_word_t  mem_wdata;
    logic                      mem_valid;
    logic                      mem_nwr;
    logic                      run;
    logic                      take_branch;

    assign opcode = stack_cpu_pkg::opcode_t'(cur_instr[15:8]);
    assign hlt = opcode == stack_cpu_pkg::op_hlt;
    assign run = !error && !hlt;
    assign prog_addr = pc;

    // neg goes through the ALU as its own operation code
    assign alu_func = (opcode == stack_cpu_pkg::op_neg) ?
        {4'h0, stack_cpu_pkg::alu_neg} : cur_instr[7:0];

    // during decode prog_data is the word after the opcode
    assign branch_offset = {{16{prog_data[15]}}, prog_data};
    assign push_value = {prog_data, immediate};

    assign take_branch = (opcode == stack_cpu_pkg::op_jmp) ||
                         (opcode == stack_cpu_pkg::op_if && cond_pass) ||
                         (opcode == stack_cpu_pkg::op_ifcmp && cmp_pass);

    assign mem_req = '{
        valid:   mem_valid,
        nwr:     mem_nwr,
        address: mem_address,
        data:    mem_wdata
    };

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state <= stack_cpu_pkg::st_fetch;
            pc <= '0;
            cur_instr <= '0;
            error <= 1'b0;
            mem_valid <= 1'b0;
            mem_nwr <= 1'b1;
        end else if (run) begin
            case (state)
                stack_cpu_pkg::st_fetch: begin
                    cur_instr <= prog_data;
                    pc <= pc + 1;
                    state <= stack_cpu_pkg::st_decode;
                end
                stack_cpu_pkg::st_decode: begin
                    state <= stack_cpu_pkg::st_fetch;
                    case (opcode)
                        stack_cpu_pkg::op_push: begin
                            pc <= pc + 1;
                            state <= stack_cpu_pkg::st_fetch2;
                        end
                        stack_cpu_pkg::op_jmp,
                        stack_cpu_pkg::op_if,
                        stack_cpu_pkg::op_ifcmp: begin
                            pc <= take_branch ? pc + branch_offset : pc + 1;
                        end
                        stack_cpu_pkg::op_swap: begin
                            state <= stack_cpu_pkg::st_push_temp;
                        end
                        stack_cpu_pkg::op_get,
                        stack_cpu_pkg::op_set: begin
                            mem_valid <= 1'b1;
                            mem_nwr <= opcode != stack_cpu_pkg::op_set;
                            state <= stack_cpu_pkg::st_wait_ready;
                        end
                        stack_cpu_pkg::op_dup,
                        stack_cpu_pkg::op_over,
                        stack_cpu_pkg::op_drop,
                        stack_cpu_pkg::op_drop2,
                        stack_cpu_pkg::op_alu,
                        stack_cpu_pkg::op_neg,
                        stack_cpu_pkg::op_nop,
                        stack_cpu_pkg::op_hlt: begin
                        end
                        default: error <= 1'b1;
                    endcase
                end
                stack_cpu_pkg::st_fetch2: begin
                    pc <= pc + 1;
                    state <= stack_cpu_pkg::st_fetch;
                end
                stack_cpu_pkg::st_wait_ready: begin
                    if (mem_ready) begin
                        mem_valid <= 1'b0;
                        mem_nwr <= 1'b1;
                        state <= stack_cpu_pkg::st_fetch;
                    end
                end
                default: state <= stack_cpu_pkg::st_fetch;
            endcase
        end
    end

    // operands are captured before decode pops them off the stack
    always_ff @(posedge clk) begin
        if (run && state == stack_cpu_pkg::st_decode) begin
            immediate <= prog_data;
            temp <= second;
            mem_address <= top[31:0];
            mem_wdata <= second[31:0];
        end
    end

    always_comb begin
        stack_cmd.write = 1'b0;
        stack_cmd.sp_delta = 3'sd0;
        stack_cmd.wr_data = alu_result;
        if (run) begin
            case (state)
                stack_cpu_pkg::st_decode: begin
                    case (opcode)
                        stack_cpu_pkg::op_dup: begin
                            stack_cmd.write = 1'b1;
                            stack_cmd.sp_delta = -3'sd1;
                            stack_cmd.wr_data = top;
                        end
                        stack_cpu_pkg::op_over: begin
                            stack_cmd.write = 1'b1;
                            stack_cmd.sp_delta = -3'sd1;
                            stack_cmd.wr_data = second;
                        end
                        // first half of swap, the old second follows from temp
                        stack_cpu_pkg::op_swap: begin
                            stack_cmd.write = 1'b1;
                            stack_cmd.sp_delta = 3'sd1;
                            stack_cmd.wr_data = top;
                        end
                        stack_cpu_pkg::op_alu: begin
                            stack_cmd.write = 1'b1;
                            stack_cmd.sp_delta = 3'sd1;
                        end
                        stack_cpu_pkg::op_neg: stack_cmd.write = 1'b1;
                        stack_cpu_pkg::op_drop,
                        stack_cpu_pkg::op_if: stack_cmd.sp_delta = 3'sd1;
                        stack_cpu_pkg::op_drop2,
                        stack_cpu_pkg::op_ifcmp,
                        stack_cpu_pkg::op_set: stack_cmd.sp_delta = 3'sd2;
                        default: begin
                        end
                    endcase
                end
                stack_cpu_pkg::st_fetch2: begin
                    stack_cmd.write = 1'b1;
                    stack_cmd.sp_delta = -3'sd1;
                    stack_cmd.wr_data = {{32{push_value[31]}}, push_value};
                end
                stack_cpu_pkg::st_push_temp: begin
                    stack_cmd.write = 1'b1;
                    stack_cmd.sp_delta = -3'sd1;
                    stack_cmd.wr_data = temp;
                end
                stack_cpu_pkg::st_wait_ready: begin
                    // a load overwrites the address on top
                    if (mem_ready && mem_nwr) begin
                        stack_cmd.write = 1'b1;
                        stack_cmd.wr_data = {{32{mem_rdata[31]}}, mem_rdata};
                    end
                end
                default: begin
                end
            endcase
        end
    end

    mem_req_stable: assert property (@(posedge clk) disable iff (!nreset)
        mem_valid && !mem_ready |=> $stable(mem_req));

    sp_delta_range: assert property (@(posedge clk) disable iff (!nreset)
        ($signed(stack_cmd.sp_delta) >= -1) && ($signed(stack_cmd.sp_delta) <= 2));

endmodule

// File: cpu/stack_cpu.sv
`timescale 1ns/1ps

module stack_cpu (
    input  logic                     clk,
    input  logic                     nreset,
    output stack_cpu_pkg::pc_t       prog_addr,
    input  stack_cpu_pkg::instr_t    prog_data,
    output stack_cpu_pkg::mem_req_t  mem_req,
    input  stack_cpu_pkg::mem_word_t mem_rdata,
    input  logic                     mem_ready,
    output logic                     hlt,
    output logic                     error
);

    stack_cpu_pkg::stack_cmd_t stack_cmd;
    stack_cpu_pkg::word_t      top;
    stack_cpu_pkg::word_t      second;
    stack_cpu_pkg::word_t      alu_result;
    logic [7:0]                alu_func;
    logic                      cond_pass;
    logic                      cmp_pass;

    cpu_control i_control (
        .clk        (clk),
        .nreset     (nreset),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .top        (top),
        .second     (second),
        .alu_result (alu_result),
        .cond_pass  (cond_pass),
        .cmp_pass   (cmp_pass),
        .alu_func   (alu_func),
        .stack_cmd  (stack_cmd),
        .hlt        (hlt),
        .error      (error)
    );

    data_stack i_stack (
        .clk       (clk),
        .nreset    (nreset),
        .stack_cmd (stack_cmd),
        .top       (top),
        .second    (second)
    );

    stack_alu i_alu (
        .top       (top),
        .second    (second),
        .func      (alu_func),
        .result    (alu_result),
        .cond_pass (cond_pass),
        .cmp_pass  (cmp_pass)
    );

endmodule

// File: tests/tb_stack_cpu.sv
`timescale 1ns/1ps

module tb_stack_cpu;

    localparam int stim_words = 1024;
    localparam int rom_words = 256;
    localparam int mem_words = 256;
    localparam int timeout_cycles = 5000;
    localparam int settle_cycles = 5;
    localparam int drive_delay = 2;

    logic                     clk;
    logic                     nreset;
    stack_cpu_pkg::pc_t       prog_addr;
    stack_cpu_pkg::instr_t    prog_data;
    stack_cpu_pkg::mem_req_t  mem_req;
    stack_cpu_pkg::mem_word_t mem_rdata;
    logic                     mem_ready;
    logic                     hlt;
    logic                     error;

    logic [31:0]              stim [stim_words];
    stack_cpu_pkg::instr_t    prog_rom [rom_words];
    stack_cpu_pkg::mem_word_t data_mem [mem_words];
    stack_cpu_pkg::mem_word_t exp_addr [$];
    stack_cpu_pkg::mem_word_t exp_data [$];
    stack_cpu_pkg::mem_req_t  req_q;
    int                       prog_len;
    int                       wait_left;
    logic                     pending;
    string                    test_name;

    stack_cpu i_dut (
        .clk       (clk),
        .nreset    (nreset),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .hlt       (hlt),
        .error     (error)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERR %s %s: expected %0h, actual %0h",
                                test_name, what, expected, actual));
        end
    endtask

    // a program that runs past its last word lands on an illegal opcode
    function automatic stack_cpu_pkg::instr_t fetch_word(input stack_cpu_pkg::pc_t addr);
        if (addr < prog_len) begin
            return prog_rom[addr];
        end
        return 16'hff00;
    endfunction

    function automatic stack_cpu_pkg::mem_word_t read_word(input stack_cpu_pkg::mem_word_t addr);
        if (addr < mem_words) begin
            return data_mem[addr];
        end
        return ~addr;
    endfunction

    task automatic record_store(input stack_cpu_pkg::mem_req_t req);
        stack_cpu_pkg::mem_word_t want_addr;
        stack_cpu_pkg::mem_word_t want_data;
        if (exp_addr.size() == 0) begin
            abort_run($sformatf("test %s made an unexpected store of %h to address %h",
                                test_name, req.data, req.address));
        end else begin
            want_addr = exp_addr.pop_front();
            want_data = exp_data.pop_front();
            check_value("store address", want_addr, req.address);
            check_value("store data", want_data, req.data);
            if (req.address < mem_words) begin
                data_mem[req.address] = req.data;
            end
        end
    endtask

    task automatic load_test(inout int pos, output logic [1:0] exp_status);
        int n_preload;
        int n_store;
        int i;
        test_name = $sformatf("%s", stim[pos]);
        exp_status = stim[pos + 1][1:0];
        n_preload = stim[pos + 2];
        n_store = stim[pos + 3];
        pos += 4;
        prog_len = 0;
        while (stim[pos] !== 32'hffffffff) begin
            if (prog_len == rom_words || pos >= stim_words - 1) begin
                abort_run($sformatf("program of test %s has no end marker", test_name));
            end
            prog_rom[prog_len] = stim[pos][15:0];
            prog_len++;
            pos++;
        end
        pos++;
        for (i = 0; i < mem_words; i++) begin
            data_mem[i] = ~i;
        end
        for (i = 0; i < n_preload; i++) begin
            data_mem[stim[pos][7:0]] = stim[pos + 1];
            pos += 2;
        end
        exp_addr.delete();
        exp_data.delete();
        for (i = 0; i < n_store; i++) begin
            exp_addr.push_back(stim[pos]);
            exp_data.push_back(stim[pos + 1]);
            pos += 2;
        end
    endtask

    // the program port and data memory models drive their outputs just after the rising edge
    always @(posedge clk) begin
        #drive_delay;
        if (req_q.valid === 1'b1 && mem_ready) begin
            if (!req_q.nwr) begin
                record_store(req_q);
            end
            pending = 1'b0;
        end
        mem_ready = 1'b0;
        if (mem_req.valid === 1'b1) begin
            if (!pending) begin
                pending = 1'b1;
                wait_left = $urandom % 4;
            end
            if (wait_left == 0) begin
                mem_ready = 1'b1;
                mem_rdata = read_word(mem_req.address);
            end else begin
                wait_left--;
            end
        end else begin
            pending = 1'b0;
        end
        req_q = mem_req;
        prog_data = fetch_word(prog_addr);
    end

    initial begin
        int pos;
        int cycles;
        int unsigned seed_draw;
        logic [1:0] exp_status;
        stack_cpu_pkg::pc_t held_addr;

        nreset = 1'b0;
        prog_data = '0;
        mem_rdata = '0;
        mem_ready = 1'b0;
        req_q = '0;
        pending = 1'b0;
        wait_left = 0;
        prog_len = 0;
        test_name = "none";
        seed_draw = $urandom(32'h4a64a84c);
        $readmemh("tests/program_input.hex", stim);
        if ($isunknown(stim[0])) begin
            abort_run("could not read the test vectors from tests/program_input.hex");
        end
        pos = 0;
        while (pos < stim_words && stim[pos] !== 32'h0) begin
            @(posedge clk);
            #drive_delay;
            nreset = 1'b0;
            load_test(pos, exp_status);
            repeat (3) @(posedge clk);
            #drive_delay;
            nreset = 1'b1;
            cycles = 0;
            while (!hlt && !error && cycles < timeout_cycles) begin
                @(posedge clk);
                #drive_delay;
                cycles++;
            end
            if (!hlt && !error) begin
                abort_run($sformatf("test %s reached neither hlt nor error in %0d cycles",
                                    test_name, timeout_cycles));
            end
            check_value("final status", exp_status, {error, hlt});
            // a stopped CPU keeps its address and stays off the memory port
            held_addr = prog_addr;
            repeat (settle_cycles) begin
                @(posedge clk);
                #drive_delay;
                check_value("request after stop", 0, mem_req.valid);
                check_value("program address after stop", held_addr, prog_addr);
            end
            check_value("stores still expected", 0, exp_addr.size());
            $display("test %s done", test_name);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

// File: tests/program_input.hex
// per test: name (ascii), status (1 hlt, 2 error), preload count, store count, then program
// words ending in ffffffff, then preload address/data pairs and expected store address/data pairs
61726974 1 0 e // arithmetic
0000 ff9c ffff 0000 0024 0000
1500 1500 1d00 0000 0020 0000 0300 1500 1500 1d01 0000 0021 0000 0300
1500 1500 1d02 0000 0022 0000 0300 1500 1500 1d03 0000 0023 0000 0300
1500 1500 1d04 0000 0024 0000 0300 1500 1500 1d06 0000 0025 0000 0300
1500 1500 1d07 0000 0026 0000 0300 1500 1500 1d08 0000 0027 0000 0300
1500 1500 1d09 0000 0028 0000 0300 1500 1500 1d0a 0000 0029 0000 0300
1200 0000 5678 1234 0000 0004 0000 1500 1500 1d05 0000 002a 0000 0300
1500 1500 1d0a 0000 002b 0000 0300 1500 1500 1d0b 0000 002c 0000 0300
0200 0e00 0000 002d 0000 0300 0c00 ffffffff
20 ffffffc0 21 ffffff78 22 4 23 ffffffbc 24 ffffffb8 25 0fffffff 26 ffffffff
27 1 28 fffff1f0 29 ffffffff 2a 23456780 2b 1 2c 0 2d fffffffc
7374636b 1 0 4 // stack operations
0000 0011 0000 0000 0022 0000 0000 0033 0000 1300 1500 0200 0000 0030 0000 0300 1100
0000 0031 0000 0300 0000 0055 0000 0000 0066 0000 1200 1900 0000 0032 0000 0300
0000 0033 0000 0300 0c00 ffffffff
30 33 31 22 32 33 33 11
62726368 1 0 c // branches
0000 0000 0000 1c01 0006 0000 2000 0000 0500 0004 0000 1000 0000 0000 0040 0000 0300
0000 0005 0000 1c01 0006 0000 2001 0000 0500 0004 0000 1001 0000 0000 0041 0000 0300
0000 ffff ffff 1c02 0006 0000 2002 0000 0500 0004 0000 1002 0000 0000 0042 0000 0300
0000 0005 0000 1c02 0006 0000 2003 0000 0500 0004 0000 1003 0000 0000 0043 0000 0300
0000 0000 0000 1c05 0006 0000 2004 0000 0500 0004 0000 1004 0000 0000 0044 0000 0300
0000 0005 0000 1c07 0006 0000 2005 0000 0500 0004 0000 1005 0000 0000 0045 0000 0300
0000 0007 0000 0000 0007 0000 1b01 0006 0000 2006 0000 0500 0004 0000 1006 0000 0000 0046
0000 0300
0000 0007 0000 0000 0009 0000 1b01 0006 0000 2007 0000 0500 0004 0000 1007 0000 0000 0047
0000 0300
0000 0009 0000 0000 0007 0000 1b02 0006 0000 2008 0000 0500 0004 0000 1008 0000 0000 0048
0000 0300
0000 ffff ffff 0000 0007 0000 1b02 0006 0000 2009 0000 0500 0004 0000 1009 0000 0000 0049
0000 0300
0000 0007 0000 0000 0009 0000 1b07 0006 0000 200a 0000 0500 0004 0000 100a 0000 0000 004a
0000 0300
0000 0009 0000 0000 0007 0000 1b06 0006 0000 200b 0000 0500 0004 0000 100b 0000 0000 004b
0000 0300 0c00 ffffffff
40 1000 41 2001 42 1002 43 2003 44 2004 45 1005 46 1006 47 2007 48 1008 49 2009
4a 100a 4b 200b
6d656d72 1 2 3 // loads under back-pressure
0000 0050 0000 0600 0200 0000 0060 0000 0300 0000 0020 0000 1d07 0000 0061 0000 0300
0000 0051 0000 0600 0000 0062 0000 0300 0c00 ffffffff
50 89abcdef 51 01234567
60 89abcdef 61 ffffffff 62 01234567
68616c74 1 0 1 // halt
0000 0007 0000 0000 0070 0000 0300 0c00 0000 0009 0000 0000 0071 0000 0300 0c00 ffffffff
70 7
6572726f 2 0 1 // illegal opcode
0000 0008 0000 0000 0072 0000 0300 ff00 0000 0009 0000 0000 0073 0000 0300 0c00 ffffffff
72 8
0 // end of tests

// File: project.f
common/stack_cpu_pkg.sv
source/data_stack.sv
source/stack_alu.sv
cpu/cpu_control.sv
cpu/stack_cpu.sv
tests/tb_stack_cpu.sv

// File: Bender.yml
package:
  name: stack_cpu

sources:
  # package first, then the blocks below the top level
  - common/stack_cpu_pkg.sv
  - source/data_stack.sv
  - source/stack_alu.sv
  - cpu/cpu_control.sv
  - cpu/stack_cpu.sv

  - target: test
    files:
      - tests/tb_stack_cpu.sv
